// File: rv_core_top.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_ctrl_pkg.sv
hdl/rv_decoder.sv
hdl/rv_imm_gen.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_pc_unit.sv
hdl/rv_core_top.sv
testbench/tb_clock_gen.sv
testbench/rv_core_tb.sv

// File: Makefile
# Verilator build and run of the single-cycle core testbench
TOP := rv_core_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f rv_core_top.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

lint:
	verilator --lint-only -Wall -f rv_core_top.f --top-module rv_core_top

clean:
	rm -rf obj_dir

// File: testbench/rv_core_tb.sv
`default_nettype none

`include "rv_macros.svh"

module rv_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int imem_words = 64;
  localparam int num_tests  = 6;

  logic                     clk;
  logic                     rst;
  logic [`RV_ILEN-1:0]      insn;
  logic [`RV_XLEN-1:0]      pc;
  logic                     halt;
  logic                     wb_we;
  logic [`RV_REG_IDX_W-1:0] wb_rd;
  logic [`RV_XLEN-1:0]      wb_data;

  logic [`RV_ILEN-1:0] imem [imem_words];
  int                  test_of [imem_words];
  int                  test_errs [num_tests];
  string               test_names [num_tests] = '{"reset and pc step", "lui and auipc",
      "register-immediate ops", "register-register ops", "branches", "ecall halt"};
  int                  prog_len = 0;
  bit                  prog_ready = 1'b0;
  int                  err_count = 0;
  int                  tests_done = 0;
  int                  tests_failed = 0;
  int                  last_test = 0;
  logic [31:0]         rnd_state = 32'h329b;

  // reference model state and its expected outputs
  logic [`RV_XLEN-1:0]      model_pc;
  logic [`RV_XLEN-1:0]      sregs [`RV_NREGS];
  logic [`RV_ILEN-1:0]      m_insn;
  logic [`RV_XLEN-1:0]      m_a;
  logic [`RV_XLEN-1:0]      m_b;
  logic [2:0]               m_f3;
  logic [6:0]               m_f7;
  logic [`RV_XLEN-1:0]      m_imm_i;
  logic [`RV_XLEN-1:0]      m_imm_u;
  logic [`RV_XLEN-1:0]      m_imm_b;
  logic                     exp_we;
  logic [`RV_REG_IDX_W-1:0] exp_rd;
  logic [`RV_XLEN-1:0]      exp_data;
  logic [`RV_XLEN-1:0]      exp_pc;
  logic                     exp_halt;
  int                       cur_test;

  tb_clock_gen i_tb_clock_gen (
    .clk_o (clk)
  );

  rv_core_top i_rv_core_top (
    .clk       (clk),
    .rst       (rst),
    .insn_i    (insn),
    .pc_o      (pc),
    .halt_o    (halt),
    .wb_we_o   (wb_we),
    .wb_rd_o   (wb_rd),
    .wb_data_o (wb_data)
  );

  assign insn = imem[pc[7:2]];

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rnd_state = xorshift(rnd_state);
    return rnd_state;
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  // integer result by funct3 where alt picks sub and the arithmetic shift
  function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] x, input logic [31:0] y);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? x - y : x + y;
      3'd1: r = x << y[4:0];
      3'd2: r = {31'b0, $signed(x) < $signed(y)};
      3'd3: r = {31'b0, x < y};
      3'd4: r = x ^ y;
      3'd5: begin
        if (alt) begin
          r = $signed(x) >>> y[4:0];
        end else begin
          r = x >> y[4:0];
        end
      end
      3'd6: r = x | y;
      default: r = x & y;
    endcase
    return r;
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] x,
                                        input logic [31:0] y);
    case (f3)
      3'd0: return x == y;
      3'd1: return x != y;
      3'd4: return $signed(x) < $signed(y);
      3'd5: return $signed(x) >= $signed(y);
      3'd6: return x < y;
      3'd7: return x >= y;
      default: return 1'b0;
    endcase
  endfunction

  assign m_insn   = imem[model_pc[7:2]];
  assign m_a      = sregs[m_insn[19:15]];
  assign m_b      = sregs[m_insn[24:20]];
  assign m_f3     = m_insn[14:12];
  assign m_f7     = m_insn[31:25];
  assign m_imm_i  = {{20{m_insn[31]}}, m_insn[31:20]};
  assign m_imm_u  = {m_insn[31:12], 12'h000};
  assign m_imm_b  = {{20{m_insn[31]}}, m_insn[7], m_insn[30:25], m_insn[11:8], 1'b0};
  assign exp_rd   = m_insn[11:7];
  assign cur_test = test_of[model_pc[7:2]];

  always_comb begin
    exp_we   = 1'b0;
    exp_data = '0;
    exp_halt = 1'b0;
    exp_pc   = model_pc + 32'd4;
    case (m_insn[6:0])
      7'b0110111: begin
        exp_we   = 1'b1;
        exp_data = m_imm_u;
      end
      7'b0010111: begin
        exp_we   = 1'b1;
        exp_data = model_pc + m_imm_u;
      end
      7'b0010011: begin
        // shift immediates need a clean funct7 and srai needs its alt value
        exp_we   = (m_f3[1:0] != 2'b01) || (m_f7 == 7'h00) || (m_f3 == 3'd5 && m_f7 == 7'h20);
        exp_data = ref_alu(m_f3, m_f3 == 3'd5 && m_f7 == 7'h20, m_a, m_imm_i);
      end
      7'b0110011: begin
        exp_we   = (m_f7 == 7'h00) || (m_f7 == 7'h20 && (m_f3 == 3'd0 || m_f3 == 3'd5));
        exp_data = ref_alu(m_f3, m_f7 == 7'h20, m_a, m_b);
      end
      7'b1100011: begin
        if (branch_taken(m_f3, m_a, m_b)) begin
          exp_pc = model_pc + m_imm_b;
        end
      end
      7'b1110011: begin
        exp_halt = (m_insn == 32'h0000_0073);
      end
      default: begin
      end
    endcase
    if (exp_rd == 5'd0) begin
      exp_we = 1'b0;
    end
  end

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      model_pc <= '0;
      for (int i = 0; i < `RV_NREGS; i++) begin
        sregs[i] <= '0;
      end
    end else begin
      if (exp_we) begin
        sregs[exp_rd] <= exp_data;
      end
      model_pc <= exp_pc;
    end
  end

  task automatic note_mismatch(input string what, input logic [31:0] got,
                               input logic [31:0] want, input int idx);
    $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, want);
    err_count++;
    test_errs[idx]++;
  endtask

  pc_in_reset: assert property (@(posedge clk) rst |-> pc == '0)
    else note_mismatch("pc_o in reset", $sampled(pc), '0, 0);
  pc_match: assert property (@(posedge clk) disable iff (rst) pc == model_pc)
    else note_mismatch("pc_o", $sampled(pc), $sampled(model_pc), $sampled(cur_test));
  we_match: assert property (@(posedge clk) disable iff (rst) wb_we == exp_we)
    else note_mismatch("wb_we_o", {31'b0, $sampled(wb_we)}, {31'b0, $sampled(exp_we)},
                       $sampled(cur_test));
  rd_match: assert property (@(posedge clk) disable iff (rst) exp_we |-> wb_rd == exp_rd)
    else note_mismatch("wb_rd_o", {27'b0, $sampled(wb_rd)}, {27'b0, $sampled(exp_rd)},
                       $sampled(cur_test));
  data_match: assert property (@(posedge clk) disable iff (rst) exp_we |-> wb_data == exp_data)
    else note_mismatch("wb_data_o", $sampled(wb_data), $sampled(exp_data), $sampled(cur_test));
  halt_match: assert property (@(posedge clk) disable iff (rst) halt == exp_halt)
    else note_mismatch("halt_o", {31'b0, $sampled(halt)}, {31'b0, $sampled(exp_halt)},
                       $sampled(cur_test));

  task automatic emit(input logic [31:0] word, input int test);
    imem[prog_len]    = word;
    test_of[prog_len] = test;
    prog_len++;
  endtask

  // lui then addi with the upper part rounded for the sign of the low 12 bits
  task automatic load_reg(input logic [4:0] rd, input logic [31:0] value, input int test);
    logic [19:0] upper;
    upper = value[31:12] + {19'b0, value[11]};
    emit(enc_u(upper, rd, 7'b0110111), test);
    emit(enc_i(value[11:0], rd, 3'd0, rd), test);
  endtask

  // a taken branch skips the counter bump behind it
  task automatic emit_branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
    emit(enc_b(13'd8, rs2, rs1, f3), 4);
    emit(enc_i(12'd1, 5'd28, 3'd0, 5'd28), 4);
  endtask

  task automatic build_program();
    for (int w = 0; w < imem_words; w++) begin
      // nop with the byte address as its immediate
      imem[w]    = enc_i(12'(w * 4), 5'd0, 3'd0, 5'd0);
      test_of[w] = num_tests - 1;
    end
    emit(32'h0000_0013, 0);
    emit(enc_u(20'(next_rand()), 5'd1, 7'b0110111), 1);
    emit(enc_u(20'(next_rand()), 5'd2, 7'b0010111), 1);
    // x3 negative and x4 positive for reuse by the branches
    load_reg(5'd3, next_rand() | 32'h8000_0000, 2);
    load_reg(5'd4, next_rand() & 32'h7fff_ffff, 2);
    emit(enc_i(12'(next_rand()), 5'd3, 3'd0, 5'd5), 2);
    emit(enc_i(12'(next_rand()), 5'd3, 3'd2, 5'd6), 2);
    emit(enc_i(12'(next_rand()), 5'd3, 3'd3, 5'd7), 2);
    emit(enc_i(12'(next_rand()), 5'd4, 3'd4, 5'd8), 2);
    emit(enc_i(12'(next_rand()), 5'd4, 3'd6, 5'd9), 2);
    emit(enc_i(12'(next_rand()), 5'd4, 3'd7, 5'd10), 2);
    emit(enc_i({7'h00, 5'(next_rand())}, 5'd4, 3'd1, 5'd11), 2);
    emit(enc_i({7'h00, 5'(next_rand())}, 5'd3, 3'd5, 5'd12), 2);
    emit(enc_i({7'h20, 5'(next_rand())}, 5'd3, 3'd5, 5'd13), 2);
    load_reg(5'd14, next_rand() & 32'h7fff_ffff, 3);
    load_reg(5'd15, next_rand() | 32'h8000_0000, 3);
    for (int k = 0; k < 8; k++) begin
      emit(enc_r(7'h00, 5'd14, 5'd15, 3'(k), 5'(16 + k)), 3);
    end
    emit(enc_r(7'h20, 5'd14, 5'd15, 3'd0, 5'd24), 3);
    emit(enc_r(7'h20, 5'd14, 5'd15, 3'd5, 5'd25), 3);
    emit(enc_r(7'h00, 5'd15, 5'd14, 3'd2, 5'd27), 3);
    emit(enc_r(7'h00, 5'd15, 5'd14, 3'd3, 5'd29), 3);
    emit(enc_r(7'h00, 5'd15, 5'd14, 3'd0, 5'd0), 3);
    emit(enc_r(7'h00, 5'd14, 5'd0, 3'd0, 5'd26), 3);
    emit_branch(3'd0, 5'd3, 5'd3);
    emit_branch(3'd0, 5'd3, 5'd4);
    emit_branch(3'd1, 5'd3, 5'd4);
    emit_branch(3'd1, 5'd3, 5'd3);
    emit_branch(3'd4, 5'd3, 5'd4);
    emit_branch(3'd4, 5'd4, 5'd3);
    emit_branch(3'd5, 5'd4, 5'd3);
    emit_branch(3'd5, 5'd3, 5'd4);
    emit_branch(3'd6, 5'd4, 5'd3);
    emit_branch(3'd6, 5'd3, 5'd4);
    emit_branch(3'd7, 5'd3, 5'd4);
    emit_branch(3'd7, 5'd4, 5'd3);
    emit(32'h0000_0073, 5);
    prog_ready = 1'b1;
  endtask

  task automatic print_test_line(input int idx);
    tests_done++;
    if (test_errs[idx] == 0) begin
      $display("test %0d %s: ok", idx, test_names[idx]);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d mismatches", idx, test_names[idx], test_errs[idx]);
    end
  endtask

  initial begin : main
    rst = 1'b1;
    build_program();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    do begin
      @(negedge clk);
      if (cur_test != last_test) begin
        print_test_line(last_test);
        last_test = cur_test;
      end
    end while (!halt);
    // let the checks of the ecall edge run first
    @(posedge clk);
    #1;
    print_test_line(last_test);
    if (tests_done != num_tests) begin
      $display("only %0d of %0d tests ran before halt", tests_done, num_tests);
    end
    $display("summary: %0d tests run, %0d failed, %0d mismatches",
             tests_done, tests_failed, err_count);
    if (err_count == 0 && tests_done == num_tests) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin : watchdog
    wait (prog_ready);
    #((prog_len + 10) * 4);
    $display("timeout: halt_o did not rise within %0d ns", (prog_len + 10) * 4);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int period_ns = 4
) (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// File: hdl/rv_core_top.sv
`default_nettype none

`include "rv_macros.svh"

module rv_core_top
  import rv_ctrl_pkg::*;
(
  input  wire                           clk,
  input  wire                           rst,
  input  wire logic [`RV_ILEN-1:0]      insn_i,
  output logic [`RV_XLEN-1:0]           pc_o,
  output logic                          halt_o,
  output logic                          wb_we_o,
  output logic [`RV_REG_IDX_W-1:0]      wb_rd_o,
  output logic [`RV_XLEN-1:0]           wb_data_o
);

  alu_op_e             alu_op;
  imm_sel_e            imm_sel;
  a_sel_e              a_sel;
  logic                b_is_imm;
  logic                reg_we;
  logic                is_branch;
  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] imm;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] alu_a;
  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] alu_result;

  rv_decoder i_rv_decoder (
    .insn_i      (insn_i),
    .alu_op_o    (alu_op),
    .imm_sel_o   (imm_sel),
    .a_sel_o     (a_sel),
    .b_is_imm_o  (b_is_imm),
    .reg_we_o    (reg_we),
    .is_branch_o (is_branch),
    .halt_o      (halt_o)
  );

  rv_imm_gen i_rv_imm_gen (
    .insn_i    (insn_i),
    .imm_sel_i (imm_sel),
    .imm_o     (imm)
  );

  // write port doubles as the retire port
  rv_regfile i_rv_regfile (
    .clk        (clk),
    .rst        (rst),
    .we_i       (reg_we),
    .rd_i       (insn_i[11:7]),
    .rd_data_i  (alu_result),
    .rs1_i      (insn_i[19:15]),
    .rs2_i      (insn_i[24:20]),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  // operand muxes
  assign alu_a = (a_sel == a_pc) ? pc : rs1_data;
  assign alu_b = b_is_imm ? imm : rs2_data;

  rv_alu i_rv_alu (
    .a_i      (alu_a),
    .b_i      (alu_b),
    .op_i     (alu_op),
    .result_o (alu_result)
  );

  rv_pc_unit i_rv_pc_unit (
    .clk         (clk),
    .rst         (rst),
    .is_branch_i (is_branch),
    .funct3_i    (insn_i[14:12]),
    .rs1_data_i  (rs1_data),
    .rs2_data_i  (rs2_data),
    .imm_i       (imm),
    .pc_o        (pc)
  );

  assign pc_o      = pc;
  assign wb_we_o   = reg_we;
  assign wb_rd_o   = insn_i[11:7];
  assign wb_data_o = alu_result;

endmodule

`default_nettype wire

// File: hdl/rv_pc_unit.sv
`default_nettype none

`include "rv_macros.svh"

module rv_pc_unit (
  input  wire                      clk,
  input  wire                      rst,
  input  wire logic                is_branch_i,
  input  wire logic [2:0]          funct3_i,
  input  wire logic [`RV_XLEN-1:0] rs1_data_i,
  input  wire logic [`RV_XLEN-1:0] rs2_data_i,
  input  wire logic [`RV_XLEN-1:0] imm_i,
  output logic [`RV_XLEN-1:0]      pc_o
);

  localparam logic [`RV_XLEN-1:0] pc_step = 4;

  logic [`RV_XLEN-1:0] pc_q;
  logic [`RV_XLEN-1:0] pc_next;
  logic                eq;
  logic                lt_s;
  logic                lt_u;
  logic                cond;

  assign eq   = rs1_data_i == rs2_data_i;
  assign lt_s = $signed(rs1_data_i) < $signed(rs2_data_i);
  assign lt_u = rs1_data_i < rs2_data_i;

  // funct3 of beq, bne, blt, bge, bltu, bgeu
  always_comb begin
    case (funct3_i)
      3'b000:  cond = eq;
      3'b001:  cond = !eq;
      3'b100:  cond = lt_s;
      3'b101:  cond = !lt_s;
      3'b110:  cond = lt_u;
      3'b111:  cond = !lt_u;
      default: cond = 1'b0;
    endcase
  end

  assign pc_next = pc_q + ((is_branch_i && cond) ? imm_i : pc_step);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign pc_o = pc_q;

endmodule

`default_nettype wire

// File: hdl/rv_alu.sv
`default_nettype none

`include "rv_macros.svh"

module rv_alu
  import rv_ctrl_pkg::*;
(
  input  wire logic [`RV_XLEN-1:0] a_i,
  input  wire logic [`RV_XLEN-1:0] b_i,
  input  wire alu_op_e             op_i,
  output logic [`RV_XLEN-1:0]      result_o
);

  localparam int shamt_w = $clog2(`RV_XLEN);

  logic [shamt_w-1:0] shamt;
  logic               lt_s;
  logic               lt_u;

  assign shamt = b_i[shamt_w-1:0];
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;

  always_comb begin
    case (op_i)
      alu_add:    result_o = a_i + b_i;
      alu_sub:    result_o = a_i - b_i;
      alu_sll:    result_o = a_i << shamt;
      alu_slt:    result_o = {{(`RV_XLEN-1){1'b0}}, lt_s};
      alu_sltu:   result_o = {{(`RV_XLEN-1){1'b0}}, lt_u};
      alu_xor:    result_o = a_i ^ b_i;
      alu_srl:    result_o = a_i >> shamt;
      // keep the sign bit filling from the left
      alu_sra:    result_o = $unsigned($signed(a_i) >>> shamt);
      alu_or:     result_o = a_i | b_i;
      alu_and:    result_o = a_i & b_i;
      alu_pass_b: result_o = b_i;
      default:    result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/rv_regfile.sv
`default_nettype none

`include "rv_macros.svh"

module rv_regfile (
  input  wire                           clk,
  input  wire                           rst,
  input  wire logic                     we_i,
  input  wire logic [`RV_REG_IDX_W-1:0] rd_i,
  input  wire logic [`RV_XLEN-1:0]      rd_data_i,
  input  wire logic [`RV_REG_IDX_W-1:0] rs1_i,
  input  wire logic [`RV_REG_IDX_W-1:0] rs2_i,
  output logic [`RV_XLEN-1:0]           rs1_data_o,
  output logic [`RV_XLEN-1:0]           rs2_data_o
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (rd_i != '0)) begin
      regs[rd_i] <= rd_data_i;
    end
  end

  // x0 is hardwired to zero
  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

// File: hdl/rv_imm_gen.sv
`default_nettype none

`include "rv_macros.svh"

module rv_imm_gen
  import rv_ctrl_pkg::*;
(
  input  wire logic [`RV_ILEN-1:0] insn_i,
  input  wire imm_sel_e            imm_sel_i,
  output logic [`RV_XLEN-1:0]      imm_o
);

  always_comb begin
    case (imm_sel_i)
      imm_u: begin
        imm_o = {insn_i[31:12], 12'b0};
      end
      imm_b: begin
        // scattered offset bits, bit 0 always zero
        imm_o = {{(`RV_XLEN-12){insn_i[31]}}, insn_i[7], insn_i[30:25],
                 insn_i[11:8], 1'b0};
      end
      imm_i: begin
        imm_o = {{(`RV_XLEN-12){insn_i[31]}}, insn_i[31:20]};
      end
      default: begin
        imm_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/rv_decoder.sv
`default_nettype none

`include "rv_macros.svh"

module rv_decoder
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;
(
  input  wire logic [`RV_ILEN-1:0] insn_i,
  output alu_op_e                  alu_op_o,
  output imm_sel_e                 imm_sel_o,
  output a_sel_e                   a_sel_o,
  output logic                     b_is_imm_o,
  output logic                     reg_we_o,
  output logic                     is_branch_o,
  output logic                     halt_o
);

  opcode_e                  opcode;
  logic [2:0]               funct3;
  logic [6:0]               funct7;
  logic [`RV_REG_IDX_W-1:0] rd;
  alu_op_e                  f3_op;
  logic                     wr_en;

  assign opcode = opcode_e'(insn_i[6:0]);
  assign funct3 = insn_i[14:12];
  assign funct7 = insn_i[31:25];
  assign rd     = insn_i[11:7];

  // funct3 to alu operation for the base funct7 encoding
  always_comb begin
    case (funct3)
      f3_add_sub: f3_op = alu_add;
      f3_sll:     f3_op = alu_sll;
      f3_slt:     f3_op = alu_slt;
      f3_sltu:    f3_op = alu_sltu;
      f3_xor:     f3_op = alu_xor;
      f3_srl_sra: f3_op = alu_srl;
      f3_or:      f3_op = alu_or;
      default:    f3_op = alu_and;
    endcase
  end

  always_comb begin
    alu_op_o    = alu_add;
    imm_sel_o   = imm_i;
    a_sel_o     = a_rs1;
    b_is_imm_o  = 1'b1;
    wr_en       = 1'b0;
    is_branch_o = 1'b0;
    halt_o      = 1'b0;

    case (opcode)
      op_lui: begin
        alu_op_o  = alu_pass_b;
        imm_sel_o = imm_u;
        wr_en     = 1'b1;
      end
      op_auipc: begin
        imm_sel_o = imm_u;
        a_sel_o   = a_pc;
        wr_en     = 1'b1;
      end
      op_branch: begin
        imm_sel_o   = imm_b;
        b_is_imm_o  = 1'b0;
        // 010 and 011 are not branches
        is_branch_o = funct3 inside {f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};
      end
      op_reg_imm: begin
        alu_op_o = f3_op;
        wr_en    = 1'b1;
        // shift immediates carry funct7 in the upper bits
        if (funct3 == f3_sll) begin
          wr_en = (funct7 == f7_base);
        end else if (funct3 == f3_srl_sra) begin
          if (funct7 == f7_alt) begin
            alu_op_o = alu_sra;
          end else begin
            wr_en = (funct7 == f7_base);
          end
        end
      end
      op_reg_reg: begin
        b_is_imm_o = 1'b0;
        if (funct7 == f7_base) begin
          alu_op_o = f3_op;
          wr_en    = 1'b1;
        end else if (funct7 == f7_alt) begin
          if (funct3 == f3_add_sub) begin
            alu_op_o = alu_sub;
            wr_en    = 1'b1;
          end else if (funct3 == f3_srl_sra) begin
            alu_op_o = alu_sra;
            wr_en    = 1'b1;
          end
        end
      end
      op_system: begin
        // only ecall, every other field zero
        halt_o = (insn_i[31:7] == '0);
      end
      default: begin
        // illegal, no write and pc steps by 4
      end
    endcase
  end

  assign reg_we_o = wr_en && (rd != '0);

endmodule

`default_nettype wire

// File: hdl/rv_ctrl_pkg.sv
`default_nettype none

package rv_ctrl_pkg;

  // operations the alu can perform
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  // immediate format
  typedef enum logic [1:0] {
    imm_i,
    imm_u,
    imm_b
  } imm_sel_e;

  // first alu operand source
  typedef enum logic {
    a_rs1 = 1'b0,
    a_pc  = 1'b1
  } a_sel_e;

endpackage

`default_nettype wire

// File: hdl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // major opcodes handled by this core
  typedef enum logic [6:0] {
    op_lui     = 7'b0110111,
    op_auipc   = 7'b0010111,
    op_branch  = 7'b1100011,
    op_reg_imm = 7'b0010011,
    op_reg_reg = 7'b0110011,
    op_system  = 7'b1110011
  } opcode_e;

  // branch conditions
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // alu groups, shared by the reg-imm and reg-reg forms
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // alt selects sub and the arithmetic right shift
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

endpackage

`default_nettype wire

// File: hdl/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data path and program counter width
`define RV_XLEN 32

// architectural register count, x0 included
`define RV_NREGS 32

// register index field width in the instruction
`define RV_REG_IDX_W 5

// instruction word width
`define RV_ILEN 32

`endif
